//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;
    localparam int nregs = 16;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    typedef logic [3:0] reg_addr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_pass_b,
        alu_add_pc
    } alu_op_e;

    typedef enum logic [3:0] {
        kind_alu,
        kind_jal,
        kind_jalr,
        kind_branch,
        kind_csr,
        kind_ecall,
        kind_mret,
        kind_ebreak,
        kind_illegal
    } kind_e;

    typedef struct packed {
        kind_e           kind;
        alu_op_e         alu_op;
        reg_addr_t       rd;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        logic            use_imm;
        logic            br_ne;
        logic            wen;
        logic [xlen-1:0] imm;
        logic [11:0]     csr_addr;
        logic            csr_set;
    } op_t;

    // architectural rd number, hence five bits
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } retire_t;

endpackage

`default_nettype wire

//--- common/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // machine mode CSRs implemented by the core
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    localparam logic [31:0] cause_ecall_m = 32'd11;

    typedef struct packed {
        logic        we;
        logic [11:0] addr;
        logic [31:0] wdata;
    } csr_req_t;

endpackage

`default_nettype wire

//--- ifu/ifu.sv
`default_nettype none

module ifu (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] next_pc,
    input  logic        halt_req,
    output logic [31:0] pc,
    output logic        fetch_valid,
    output logic        halted
);

    logic running;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= core_pkg::reset_pc;
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (!halted) begin
            if (running && halt_req) begin
                // stop fetching, pc stays on the halting word
                running <= 1'b0;
                halted  <= 1'b1;
            end else begin
                running <= 1'b1;
                if (running) begin
                    pc <= next_pc;
                end
            end
        end
    end

    assign fetch_valid = running;

    // every fetched word sits on a word boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        fetch_valid |-> (pc[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- idu/idu.sv
`default_nettype none

module idu (
    input  logic [31:0]      inst,
    output core_pkg::op_t    op
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        csr_known;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign funct12 = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // only the four machine CSRs exist
    assign csr_known = funct12 inside {csr_pkg::csr_mstatus, csr_pkg::csr_mtvec,
                                       csr_pkg::csr_mepc, csr_pkg::csr_mcause};

    always_comb begin
        op.kind     = core_pkg::kind_illegal;
        op.alu_op   = core_pkg::alu_add;
        // RV32E, upper index bit dropped
        op.rd       = inst[10:7];
        op.rs1      = inst[18:15];
        op.rs2      = inst[23:20];
        op.use_imm  = 1'b0;
        op.br_ne    = 1'b0;
        op.wen      = 1'b0;
        op.imm      = imm_i;
        op.csr_addr = funct12;
        op.csr_set  = 1'b0;

        case (opcode)
            core_pkg::opc_lui: begin
                op.kind    = core_pkg::kind_alu;
                op.alu_op  = core_pkg::alu_pass_b;
                op.use_imm = 1'b1;
                op.wen     = 1'b1;
                op.imm     = imm_u;
            end
            core_pkg::opc_auipc: begin
                op.kind    = core_pkg::kind_alu;
                op.alu_op  = core_pkg::alu_add_pc;
                op.use_imm = 1'b1;
                op.wen     = 1'b1;
                op.imm     = imm_u;
            end
            core_pkg::opc_jal: begin
                op.kind = core_pkg::kind_jal;
                op.wen  = 1'b1;
                op.imm  = imm_j;
            end
            core_pkg::opc_jalr: begin
                if (funct3 == 3'b000) begin
                    op.kind = core_pkg::kind_jalr;
                    op.wen  = 1'b1;
                end
            end
            core_pkg::opc_branch: begin
                op.imm = imm_b;
                // beq and bne only
                if (funct3[2:1] == 2'b00) begin
                    op.kind  = core_pkg::kind_branch;
                    op.br_ne = funct3[0];
                end
            end
            core_pkg::opc_imm: begin
                if (funct3 == 3'b000) begin
                    op.kind    = core_pkg::kind_alu;
                    op.use_imm = 1'b1;
                    op.wen     = 1'b1;
                end
            end
            core_pkg::opc_reg: begin
                if (funct3 == 3'b000 && (funct7 == 7'h00 || funct7 == 7'h20)) begin
                    op.kind   = core_pkg::kind_alu;
                    op.alu_op = funct7[5] ? core_pkg::alu_sub : core_pkg::alu_add;
                    op.wen    = 1'b1;
                end
            end
            core_pkg::opc_system: begin
                if ((funct3 == 3'b001 || funct3 == 3'b010) && csr_known) begin
                    op.kind    = core_pkg::kind_csr;
                    op.wen     = 1'b1;
                    op.csr_set = funct3[1];
                end else if (funct3 == 3'b000 && inst[19:15] == 5'd0
                             && inst[11:7] == 5'd0) begin
                    case (funct12)
                        12'h000: op.kind = core_pkg::kind_ecall;
                        12'h001: op.kind = core_pkg::kind_ebreak;
                        12'h302: op.kind = core_pkg::kind_mret;
                        default: op.kind = core_pkg::kind_illegal;
                    endcase
                end
            end
            default: op.kind = core_pkg::kind_illegal;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`default_nettype none

module register_file (
    input  logic                clk,
    input  logic                wen,
    input  core_pkg::reg_addr_t waddr,
    input  logic [31:0]         wdata,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    output logic [31:0]         rdata1,
    output logic [31:0]         rdata2
);

    logic [core_pkg::xlen-1:0] regs [core_pkg::nregs];

    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never stored and always reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // a written value reaches read port 1 in the next cycle
    a_write_visible: assert property (@(posedge clk)
        (wen && waddr != '0) |=> (raddr1 != $past(waddr) || rdata1 == $past(wdata)));

endmodule

`default_nettype wire

//--- hdl/csr_file.sv
`default_nettype none

module csr_file (
    input  logic              clk,
    input  logic              reset,
    input  csr_pkg::csr_req_t req,
    input  logic [11:0]       raddr,
    output logic [31:0]       rdata,
    input  logic              trap,
    input  logic [31:0]       trap_pc,
    output logic [31:0]       mtvec,
    output logic [31:0]       mepc
);

    logic [31:0] mstatus;
    logic [31:0] mcause;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (trap) begin
            // ecall entry
            mepc   <= trap_pc;
            mcause <= csr_pkg::cause_ecall_m;
        end else if (req.we) begin
            case (req.addr)
                csr_pkg::csr_mstatus: mstatus <= req.wdata;
                csr_pkg::csr_mtvec:   mtvec   <= req.wdata;
                csr_pkg::csr_mepc:    mepc    <= req.wdata;
                csr_pkg::csr_mcause:  mcause  <= req.wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (raddr)
            csr_pkg::csr_mstatus: rdata = mstatus;
            csr_pkg::csr_mtvec:   rdata = mtvec;
            csr_pkg::csr_mepc:    rdata = mepc;
            csr_pkg::csr_mcause:  rdata = mcause;
            default:              rdata = '0;
        endcase
    end

    // ecall and a csr instruction cannot retire together
    a_no_trap_and_write: assert property (@(posedge clk) disable iff (reset)
        !(trap && req.we));

endmodule

`default_nettype wire

//--- exu/exu.sv
`default_nettype none

module exu (
    input  core_pkg::op_t     op,
    input  logic [31:0]       pc,
    input  logic [31:0]       rs1_data,
    input  logic [31:0]       rs2_data,
    input  logic [31:0]       csr_rdata,
    input  logic              valid,
    output logic [31:0]       result,
    output logic              taken,
    output csr_pkg::csr_req_t csr_req,
    output logic              trap
);

    logic [31:0] operand_b;
    logic [31:0] alu_out;

    assign operand_b = op.use_imm ? op.imm : rs2_data;

    always_comb begin
        case (op.alu_op)
            core_pkg::alu_add:    alu_out = rs1_data + operand_b;
            core_pkg::alu_sub:    alu_out = rs1_data - operand_b;
            core_pkg::alu_pass_b: alu_out = operand_b;
            default:              alu_out = pc + operand_b;
        endcase
    end

    always_comb begin
        case (op.kind)
            // link value
            core_pkg::kind_jal,
            core_pkg::kind_jalr: result = pc + 32'd4;
            // old csr value goes to rd
            core_pkg::kind_csr:  result = csr_rdata;
            default:             result = alu_out;
        endcase
    end

    assign taken = (rs1_data == rs2_data) ^ op.br_ne;

    assign csr_req.we    = valid && (op.kind == core_pkg::kind_csr);
    assign csr_req.addr  = op.csr_addr;
    assign csr_req.wdata = op.csr_set ? (csr_rdata | rs1_data) : rs1_data;

    assign trap = valid && (op.kind == core_pkg::kind_ecall);

endmodule

`default_nettype wire

//--- hdl/pcu.sv
`default_nettype none

module pcu (
    input  core_pkg::op_t op,
    input  logic          taken,
    input  logic [31:0]   pc,
    input  logic [31:0]   rs1_data,
    input  logic [31:0]   mtvec,
    input  logic [31:0]   mepc,
    output logic [31:0]   next_pc,
    output logic          halt_req
);

    logic [31:0] jalr_target;

    assign jalr_target = rs1_data + op.imm;

    always_comb begin
        next_pc  = pc + 32'd4;
        halt_req = 1'b0;
        case (op.kind)
            core_pkg::kind_jal:    next_pc = pc + op.imm;
            core_pkg::kind_branch: if (taken) next_pc = pc + op.imm;
            core_pkg::kind_jalr:   next_pc = {jalr_target[31:1], 1'b0};
            // direct mode only
            core_pkg::kind_ecall:  next_pc = {mtvec[31:2], 2'b00};
            core_pkg::kind_mret:   next_pc = mepc;
            core_pkg::kind_ebreak,
            core_pkg::kind_illegal: begin
                next_pc  = pc;
                halt_req = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/core_top.sv
`default_nettype none

module core_top (
    input  logic              clk,
    input  logic              reset,
    output logic [31:0]       pc,
    input  logic [31:0]       inst,
    output core_pkg::retire_t retire,
    output logic              halted
);

    logic              fetch_valid;
    logic [31:0]       next_pc;
    logic              halt_req;
    core_pkg::op_t     op;
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;
    logic [31:0]       result;
    logic              taken;
    csr_pkg::csr_req_t csr_req;
    logic [31:0]       csr_rdata;
    logic              trap;
    logic [31:0]       mtvec;
    logic [31:0]       mepc;

    ifu i_ifu (
        .clk         (clk),
        .reset       (reset),
        .next_pc     (next_pc),
        .halt_req    (halt_req),
        .pc          (pc),
        .fetch_valid (fetch_valid),
        .halted      (halted)
    );

    idu i_idu (
        .inst (inst),
        .op   (op)
    );

    register_file i_register_file (
        .clk    (clk),
        .wen    (fetch_valid & op.wen),
        .waddr  (op.rd),
        .wdata  (result),
        .raddr1 (op.rs1),
        .raddr2 (op.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    csr_file i_csr_file (
        .clk     (clk),
        .reset   (reset),
        .req     (csr_req),
        .raddr   (op.csr_addr),
        .rdata   (csr_rdata),
        .trap    (trap),
        .trap_pc (pc),
        .mtvec   (mtvec),
        .mepc    (mepc)
    );

    exu i_exu (
        .op        (op),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .csr_rdata (csr_rdata),
        .valid     (fetch_valid),
        .result    (result),
        .taken     (taken),
        .csr_req   (csr_req),
        .trap      (trap)
    );

    pcu i_pcu (
        .op       (op),
        .taken    (taken),
        .pc       (pc),
        .rs1_data (rs1_data),
        .mtvec    (mtvec),
        .mepc     (mepc),
        .next_pc  (next_pc),
        .halt_req (halt_req)
    );

    // rd reads as zero when nothing is written
    assign retire.valid = fetch_valid;
    assign retire.pc    = pc;
    assign retire.rd    = op.wen ? {1'b0, op.rd} : 5'd0;
    assign retire.data  = result;

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // released on a falling edge after three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/tb_core.sv
`default_nettype none

module tb_core;

    localparam int plen = 35;
    localparam int halt_slot = 27;
    localparam int limit = (plen + 20) * 8;

    logic clk;
    logic reset;
    logic [31:0] pc;
    logic [31:0] inst;
    logic halted;
    core_pkg::retire_t retire;

    logic [31:0] prog [plen];
    logic [4:0] exp_rd [plen];
    logic [31:0] exp_data [plen];
    logic exp_chk [plen];
    logic [31:0] exp_next [plen];

    logic [31:0] fetch_slot;
    logic [31:0] ret_slot;
    logic in_range;
    logic [4:0] cur_rd;
    logic [31:0] cur_data;
    logic cur_chk;
    logic [31:0] cur_next;
    logic [31:0] prev_next;
    logic [31:0] prev_pc;

    int seed = 32'h36685c41;
    int errors = 0;
    int retired = 0;
    int tests_done = 0;
    int t_idx;
    int done_slot [5] = '{0, 7, 17, 25, 27};
    string test_name [5] = '{"reset", "arithmetic", "control flow", "csr access", "trap"};

    tb_clock i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    core_top i_core_top (
        .clk    (clk),
        .reset  (reset),
        .pc     (pc),
        .inst   (inst),
        .retire (retire),
        .halted (halted)
    );

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd);
        return {f7, rs2, rs1, 3'b000, rd, core_pkg::opc_reg};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::opc_jal};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::opc_branch};
    endfunction

    task automatic put(input int s, input logic [31:0] w, input logic [4:0] rd,
                       input logic [31:0] d, input logic chk, input int nxt);
        prog[s]     = w;
        exp_rd[s]   = rd;
        exp_data[s] = d;
        exp_chk[s]  = chk;
        exp_next[s] = core_pkg::reset_pc + 32'(4 * nxt);
    endtask

    // instruction memory answers within the cycle, driven on the falling edge
    assign fetch_slot = (pc - core_pkg::reset_pc) >> 2;
    always @(negedge clk) begin
        inst <= (fetch_slot < 32'(plen)) ? prog[fetch_slot[5:0]] : 32'h0;
    end

    always_comb begin
        ret_slot = (retire.pc - core_pkg::reset_pc) >> 2;
        in_range = ret_slot < 32'(plen);
        cur_rd   = in_range ? exp_rd[ret_slot[5:0]] : 5'd0;
        cur_data = in_range ? exp_data[ret_slot[5:0]] : 32'h0;
        cur_chk  = in_range ? exp_chk[ret_slot[5:0]] : 1'b0;
        cur_next = in_range ? exp_next[ret_slot[5:0]] : 32'h0;
    end

    always @(posedge clk) begin
        prev_next <= cur_next;
        prev_pc   <= pc;
        if (!reset && retire.valid && in_range) begin
            retired++;
            for (t_idx = 0; t_idx < 5; t_idx++) begin
                if (ret_slot == 32'(done_slot[t_idx])) begin
                    $display("test %0d %s done, errors %0d", t_idx + 1, test_name[t_idx], errors);
                    tests_done++;
                end
            end
        end
    end

    a_reset_pc: assert property (@(posedge clk) reset |=> (pc == core_pkg::reset_pc))
        else begin
            $display("Error at %0t: pc = %h, expected %h", $time, $sampled(pc),
                     core_pkg::reset_pc);
            errors++;
        end
    a_reset_valid: assert property (@(posedge clk) reset |=> !retire.valid)
        else begin
            $display("Error at %0t: retire.valid = 1, expected 0", $time);
            errors++;
        end
    a_first_pc: assert property (@(posedge clk) disable iff (reset)
        $rose(retire.valid) |-> (retire.pc == core_pkg::reset_pc))
        else begin
            $display("Error at %0t: retire.pc = %h, expected %h", $time,
                     $sampled(retire.pc), core_pkg::reset_pc);
            errors++;
        end
    a_in_program: assert property (@(posedge clk) disable iff (reset)
        retire.valid |-> in_range)
        else begin
            $display("retired pc %h lies outside the program at %0t", $sampled(retire.pc), $time);
            errors++;
        end
    a_rd: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && in_range) |-> (retire.rd == cur_rd))
        else begin
            $display("Error at %0t: retire.rd = %0d, expected %0d", $time,
                     $sampled(retire.rd), $sampled(cur_rd));
            errors++;
        end
    a_data: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && in_range && cur_chk) |-> (retire.data == cur_data))
        else begin
            $display("Error at %0t: retire.data = %h, expected %h", $time,
                     $sampled(retire.data), $sampled(cur_data));
            errors++;
        end
    a_next_pc: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && in_range) |=> (pc == prev_next))
        else begin
            $display("Error at %0t: pc = %h, expected %h", $time, $sampled(pc),
                     $sampled(prev_next));
            errors++;
        end
    a_halts: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && ret_slot == 32'(halt_slot)) |=> halted)
        else begin
            $display("core did not halt after ebreak at %0t", $time);
            errors++;
        end
    a_stopped: assert property (@(posedge clk) disable iff (reset)
        halted |=> (halted && !retire.valid))
        else begin
            $display("core retired or left the halted state at %0t", $time);
            errors++;
        end
    a_frozen_pc: assert property (@(posedge clk) disable iff (reset)
        halted |=> (pc == prev_pc))
        else begin
            $display("Error at %0t: pc = %h, expected %h", $time, $sampled(pc),
                     $sampled(prev_pc));
            errors++;
        end

    initial begin
        #(limit);
        $display("watchdog expired after %0d time units", limit);
        $display("sim failed");
        $finish;
    end

    initial begin
        int i;
        logic [31:0] r;
        logic [19:0] ua;
        logic [19:0] ub;
        logic [11:0] ia;
        logic [31:0] x1;
        logic [31:0] x2;
        inst = 32'h0;
        // unused slots hold an unknown opcode tagged with their index
        for (i = 0; i < plen; i++) begin
            put(i, {i[24:0], 7'h7f}, 5'd0, 32'h0, 1'b0, i + 1);
        end
        r  = $random(seed);
        ua = r[19:0];
        r  = $random(seed);
        ia = r[11:0];
        r  = $random(seed);
        ub = r[19:0];
        x1 = {ua, 12'h000} + {{20{ia[11]}}, ia};
        x2 = core_pkg::reset_pc + 32'd8 + {ub, 12'h000};

        put(0, u_word(ua, 5'd1, core_pkg::opc_lui), 5'd1, {ua, 12'h000}, 1'b1, 1);
        put(1, i_word(ia, 5'd1, 3'b000, 5'd1, core_pkg::opc_imm), 5'd1, x1, 1'b1, 2);
        put(2, u_word(ub, 5'd2, core_pkg::opc_auipc), 5'd2, x2, 1'b1, 3);
        put(3, r_word(7'h00, 5'd2, 5'd1, 5'd3), 5'd3, x1 + x2, 1'b1, 4);
        put(4, r_word(7'h20, 5'd1, 5'd3, 5'd4), 5'd4, x2, 1'b1, 5);
        // x0 write retires its value with rd 0
        put(5, i_word(12'd5, 5'd1, 3'b000, 5'd0, core_pkg::opc_imm), 5'd0, x1 + 32'd5, 1'b1, 6);
        put(6, r_word(7'h00, 5'd4, 5'd0, 5'd5), 5'd5, x2, 1'b1, 7);

        put(7, j_word(21'd8, 5'd6), 5'd6, 32'h8000_0020, 1'b1, 9);
        put(9, u_word(20'h0, 5'd7, core_pkg::opc_auipc), 5'd7, 32'h8000_0024, 1'b1, 10);
        put(10, i_word(12'd12, 5'd7, 3'b000, 5'd8, core_pkg::opc_jalr), 5'd8, 32'h8000_002c,
            1'b1, 12);
        put(12, b_word(13'd8, 5'd2, 5'd4, 3'b000), 5'd0, 32'h0, 1'b0, 14);
        put(14, b_word(13'd8, 5'd6, 5'd0, 3'b000), 5'd0, 32'h0, 1'b0, 15);
        put(15, b_word(13'd8, 5'd6, 5'd0, 3'b001), 5'd0, 32'h0, 1'b0, 17);

        // handler sits at slot 30
        put(17, i_word(12'h054, 5'd7, 3'b000, 5'd10, core_pkg::opc_imm), 5'd10, 32'h8000_0078,
            1'b1, 18);
        put(18, i_word(csr_pkg::csr_mtvec, 5'd10, 3'b001, 5'd9, core_pkg::opc_system), 5'd9,
            32'h0, 1'b1, 19);
        put(19, i_word(csr_pkg::csr_mtvec, 5'd0, 3'b010, 5'd11, core_pkg::opc_system), 5'd11,
            32'h8000_0078, 1'b1, 20);
        put(20, i_word(12'h0f0, 5'd0, 3'b000, 5'd13, core_pkg::opc_imm), 5'd13, 32'h0f0, 1'b1, 21);
        put(21, i_word(csr_pkg::csr_mstatus, 5'd13, 3'b010, 5'd0, core_pkg::opc_system), 5'd0,
            32'h0, 1'b1, 22);
        put(22, i_word(12'h00f, 5'd0, 3'b000, 5'd14, core_pkg::opc_imm), 5'd14, 32'h00f, 1'b1, 23);
        put(23, i_word(csr_pkg::csr_mstatus, 5'd14, 3'b010, 5'd12, core_pkg::opc_system), 5'd12,
            32'h0f0, 1'b1, 24);
        put(24, i_word(csr_pkg::csr_mstatus, 5'd0, 3'b010, 5'd15, core_pkg::opc_system), 5'd15,
            32'h0ff, 1'b1, 25);

        put(25, 32'h0000_0073, 5'd0, 32'h0, 1'b0, 30);
        put(30, i_word(csr_pkg::csr_mcause, 5'd0, 3'b010, 5'd1, core_pkg::opc_system), 5'd1,
            32'd11, 1'b1, 31);
        put(31, i_word(csr_pkg::csr_mepc, 5'd0, 3'b010, 5'd2, core_pkg::opc_system), 5'd2,
            32'h8000_0064, 1'b1, 32);
        put(32, i_word(12'd4, 5'd2, 3'b000, 5'd2, core_pkg::opc_imm), 5'd2, 32'h8000_0068, 1'b1, 33);
        put(33, i_word(csr_pkg::csr_mepc, 5'd2, 3'b001, 5'd0, core_pkg::opc_system), 5'd0,
            32'h8000_0064, 1'b1, 34);
        put(34, 32'h3020_0073, 5'd0, 32'h0, 1'b0, 26);
        put(26, i_word(12'd1, 5'd1, 3'b000, 5'd3, core_pkg::opc_imm), 5'd3, 32'd12, 1'b1, 27);
        put(halt_slot, 32'h0010_0073, 5'd0, 32'h0, 1'b0, halt_slot);

        wait (reset == 1'b0);
        wait (halted == 1'b1);
        repeat (5) @(posedge clk);
        @(negedge clk);
        $display("test 6 halt done, errors %0d", errors);
        tests_done++;
        $display("tests %0d of 6, retired %0d, errors %0d", tests_done, retired, errors);
        if (errors == 0 && tests_done == 6) begin
            $display("sim passed");
        end else begin
            if (tests_done != 6) begin
                $display("the core halted before every test reached its end");
            end
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
common/core_pkg.sv
common/csr_pkg.sv
ifu/ifu.sv
idu/idu.sv
hdl/register_file.sv
hdl/csr_file.sv
exu/exu.sv
hdl/pcu.sv
hdl/core_top.sv
sim/tb_clock.sv
sim/tb_core.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_core \
    --Mdir obj_dir -o tb_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
